//--- Bender.yml
package:
  name: proc

sources:
  - rtl/proc_pkg.sv
  - rtl/fetch.sv
  - rtl/decode.sv
  - rtl/execute.sv
  - rtl/memory.sv
  - rtl/hazard_unit.sv
  - rtl/proc.sv
  - target: test
    files:
      - verification/tb_proc.sv

//--- rtl/decode.sv
`timescale 1ns/1ps
`default_nettype none

module decode import proc_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  if_id_t   if_id,
    input  logic     stall,
    input  logic     flush,
    input  retire_t  wb,
    output id_ex_t   id_ex,
    output reg_idx_t rs1_idx,
    output reg_idx_t rs2_idx,
    output logic     rti_seen
);

    xlen_t      instr;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_idx_t   rd;
    op_t        op;
    xlen_t      imm;
    logic       uses_rs1;
    logic       uses_rs2;
    logic       writes_rd;
    xlen_t      regs [32];

    assign instr  = if_id.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd     = instr[11:7];

    // Opcode and function fields to op, with the matching immediate
    always_comb begin
        op  = OP_INVALID;
        imm = '0;
        case (opcode)
            OPC_LUI: begin
                op  = OP_LUI;
                imm = {instr[31:12], 12'b0};
            end
            OPC_OP_IMM: begin
                op  = (funct3 == 3'b000) ? OP_ADDI : OP_INVALID;
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            OPC_OP: begin
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: op = OP_ADD;
                    {7'b0100000, 3'b000}: op = OP_SUB;
                    {7'b0000000, 3'b111}: op = OP_AND;
                    {7'b0000000, 3'b110}: op = OP_OR;
                    {7'b0000000, 3'b100}: op = OP_XOR;
                    {7'b0000000, 3'b010}: op = OP_SLT;
                    default:              op = OP_INVALID;
                endcase
            end
            OPC_LOAD: begin
                op  = (funct3 == 3'b010) ? OP_LW : OP_INVALID;
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            OPC_STORE: begin
                op  = (funct3 == 3'b010) ? OP_SW : OP_INVALID;
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            OPC_BRANCH: begin
                op  = (funct3 == 3'b000) ? OP_BEQ :
                      (funct3 == 3'b001) ? OP_BNE : OP_INVALID;
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            OPC_JAL: begin
                op  = OP_JAL;
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            OPC_RTI: op = OP_RTI;
            default: op = OP_INVALID;
        endcase
    end

    assign uses_rs1  = op inside {OP_ADDI, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                                  OP_SLT, OP_LW, OP_SW, OP_BEQ, OP_BNE};
    assign uses_rs2  = op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT,
                                  OP_SW, OP_BEQ, OP_BNE};
    assign writes_rd = op inside {OP_LUI, OP_ADDI, OP_ADD, OP_SUB, OP_AND, OP_OR,
                                  OP_XOR, OP_SLT, OP_LW, OP_JAL};

    // Unused sources read as x0 so they never match a producer
    assign rs1_idx  = (if_id.valid && uses_rs1) ? instr[19:15] : '0;
    assign rs2_idx  = (if_id.valid && uses_rs2) ? instr[24:20] : '0;
    assign rti_seen = if_id.valid && (op == OP_RTI);

    always_ff @(posedge clk) begin
        if (wb.valid && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // x0 reads zero; a same-cycle write is bypassed to the read
    function automatic xlen_t read_reg(reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (wb.valid && wb.rd == idx) begin
            return wb.data;
        end
        return regs[idx];
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex <= '0;
        end else if (stall || flush || !if_id.valid) begin
            id_ex <= '0;
        end else begin
            id_ex.op        <= op;
            id_ex.rs1       <= rs1_idx;
            id_ex.rs2       <= rs2_idx;
            id_ex.rd        <= rd;
            id_ex.rs1_val   <= read_reg(rs1_idx);
            id_ex.rs2_val   <= read_reg(rs2_idx);
            id_ex.imm       <= imm;
            id_ex.pc        <= if_id.pc;
            id_ex.reg_write <= writes_rd && (rd != '0);
            id_ex.valid     <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- rtl/execute.sv
`timescale 1ns/1ps
`default_nettype none

module execute import proc_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  id_ex_t   id_ex,
    input  fwd_sel_t fwd1,
    input  fwd_sel_t fwd2,
    input  xlen_t    mem_fwd,
    input  xlen_t    wb_fwd,
    output ex_mem_t  ex_mem,
    output logic     branch_taken,
    output xlen_t    branch_target
);

    xlen_t op_a;
    xlen_t op_b;
    xlen_t alu_result;

    function automatic xlen_t pick(fwd_sel_t sel, xlen_t reg_val, xlen_t mem_val,
                                   xlen_t wb_val);
        case (sel)
            FROM_MEM: return mem_val;
            FROM_WB:  return wb_val;
            default:  return reg_val;
        endcase
    endfunction

    assign op_a = pick(fwd1, id_ex.rs1_val, mem_fwd, wb_fwd);
    assign op_b = pick(fwd2, id_ex.rs2_val, mem_fwd, wb_fwd);

    // Loads and stores produce their address here, JAL its link value
    always_comb begin
        case (id_ex.op)
            OP_LUI:  alu_result = id_ex.imm;
            OP_ADDI: alu_result = op_a + id_ex.imm;
            OP_ADD:  alu_result = op_a + op_b;
            OP_SUB:  alu_result = op_a - op_b;
            OP_AND:  alu_result = op_a & op_b;
            OP_OR:   alu_result = op_a | op_b;
            OP_XOR:  alu_result = op_a ^ op_b;
            OP_SLT:  alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            OP_LW,
            OP_SW:   alu_result = op_a + id_ex.imm;
            OP_JAL:  alu_result = id_ex.pc + 32'd4;
            default: alu_result = '0;
        endcase
    end

    // Branches and JAL resolve here
    assign branch_taken  = id_ex.valid &&
                           ((id_ex.op == OP_BEQ && op_a == op_b) ||
                            (id_ex.op == OP_BNE && op_a != op_b) ||
                            (id_ex.op == OP_JAL));
    assign branch_target = id_ex.pc + id_ex.imm;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem <= '0;
        end else begin
            ex_mem.alu_result <= alu_result;
            ex_mem.store_data <= op_b;
            ex_mem.pc         <= id_ex.pc;
            ex_mem.rd         <= id_ex.rd;
            ex_mem.op         <= id_ex.op;
            ex_mem.reg_write  <= id_ex.reg_write && id_ex.valid;
            ex_mem.valid      <= id_ex.valid;
        end
    end

endmodule

`default_nettype wire

//--- rtl/fetch.sv
`timescale 1ns/1ps
`default_nettype none

module fetch import proc_pkg::*; #(
    parameter xlen_t RESET_PC   = 32'h0000_0000,
    parameter xlen_t IRQ_VECTOR = 32'h0000_0100
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   stall,
    input  logic   branch_taken,
    input  xlen_t  branch_target,
    input  logic   irq_take,
    input  logic   rti_seen,
    input  xlen_t  imem_data,
    output xlen_t  imem_addr,
    output if_id_t if_id
);

    xlen_t pc;
    xlen_t epc;
    xlen_t pc_plus4;

    assign pc_plus4  = pc + 32'd4;
    // Instruction memory answers within the same cycle
    assign imem_addr = pc;

    // Redirects outrank the load-use stall
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc    <= RESET_PC;
            epc   <= RESET_PC;
            if_id <= '0;
        end else if (branch_taken) begin
            pc    <= branch_target;
            if_id <= '0;
        end else if (irq_take) begin
            // Oldest instruction that has not reached execute
            epc   <= if_id.valid ? if_id.pc : pc;
            pc    <= IRQ_VECTOR;
            if_id <= '0;
        end else if (rti_seen) begin
            pc    <= epc;
            if_id <= '0;
        end else if (!stall) begin
            pc          <= pc_plus4;
            if_id.instr <= imem_data;
            if_id.pc    <= pc;
            if_id.valid <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- rtl/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit import proc_pkg::*; (
    input  reg_idx_t rs1_idx,
    input  reg_idx_t rs2_idx,
    input  id_ex_t   id_ex,
    input  ex_mem_t  ex_mem,
    input  retire_t  retire,
    output fwd_sel_t fwd1,
    output fwd_sel_t fwd2,
    output logic     stall
);

    logic load_in_ex;

    // Newer producer in memory beats the retiring one
    function automatic fwd_sel_t select(reg_idx_t src, ex_mem_t em, retire_t rt);
        if (src == '0) begin
            return REG;
        end
        if (em.valid && em.reg_write && em.rd == src) begin
            return FROM_MEM;
        end
        if (rt.valid && rt.rd == src) begin
            return FROM_WB;
        end
        return REG;
    endfunction

    assign fwd1 = select(id_ex.rs1, ex_mem, retire);
    assign fwd2 = select(id_ex.rs2, ex_mem, retire);

    // Load data only exists after memory, so hold the consumer one cycle
    assign load_in_ex = id_ex.valid && id_ex.reg_write && (id_ex.op == OP_LW);
    assign stall      = load_in_ex &&
                        ((id_ex.rd == rs1_idx) || (id_ex.rd == rs2_idx));

endmodule

`default_nettype wire

//--- rtl/memory.sv
`timescale 1ns/1ps
`default_nettype none

module memory import proc_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  ex_mem_t ex_mem,
    input  xlen_t   dmem_rdata,
    output xlen_t   dmem_raddr,
    output store_t  dmem_wr,
    output retire_t retire
);

    logic is_load;
    logic is_store;

    assign is_load  = ex_mem.valid && (ex_mem.op == OP_LW);
    assign is_store = ex_mem.valid && (ex_mem.op == OP_SW);

    // Data memory reads back combinationally
    assign dmem_raddr   = ex_mem.alu_result;
    assign dmem_wr.valid = is_store;
    assign dmem_wr.addr  = ex_mem.alu_result;
    assign dmem_wr.data  = ex_mem.store_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retire <= '0;
        end else begin
            retire.valid <= ex_mem.reg_write || is_store;
            // Stores show up in the trace with rd zero
            retire.rd    <= is_store ? '0 : ex_mem.rd;
            if (is_load) begin
                retire.data <= dmem_rdata;
            end else if (is_store) begin
                retire.data <= ex_mem.store_data;
            end else begin
                retire.data <= ex_mem.alu_result;
            end
            retire.pc    <= ex_mem.pc;
        end
    end

endmodule

`default_nettype wire

//--- rtl/proc.sv
`timescale 1ns/1ps
`default_nettype none

module proc import proc_pkg::*; #(
    parameter xlen_t RESET_PC   = 32'h0000_0000,
    parameter xlen_t IRQ_VECTOR = 32'h0000_0100
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    irq,
    input  xlen_t   imem_data,
    input  xlen_t   dmem_rdata,
    output xlen_t   imem_addr,
    output xlen_t   dmem_raddr,
    output store_t  dmem_wr,
    output retire_t retire
);

    if_id_t   if_id;
    id_ex_t   id_ex;
    ex_mem_t  ex_mem;
    retire_t  wb;
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    fwd_sel_t fwd1;
    fwd_sel_t fwd2;
    logic     stall;
    logic     flush;
    logic     branch_taken;
    xlen_t    branch_target;
    logic     rti_seen;
    logic     irq_take;
    logic     irq_latch;

    fetch #(
        .RESET_PC   (RESET_PC),
        .IRQ_VECTOR (IRQ_VECTOR)
    ) u_fetch (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall         (stall),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .irq_take      (irq_take),
        .rti_seen      (rti_seen),
        .imem_data     (imem_data),
        .imem_addr     (imem_addr),
        .if_id         (if_id)
    );

    decode u_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .if_id    (if_id),
        .stall    (stall),
        .flush    (flush),
        .wb       (wb),
        .id_ex    (id_ex),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .rti_seen (rti_seen)
    );

    execute u_execute (
        .clk           (clk),
        .rst_n         (rst_n),
        .id_ex         (id_ex),
        .fwd1          (fwd1),
        .fwd2          (fwd2),
        .mem_fwd       (ex_mem.alu_result),
        .wb_fwd        (retire.data),
        .ex_mem        (ex_mem),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    memory u_memory (
        .clk        (clk),
        .rst_n      (rst_n),
        .ex_mem     (ex_mem),
        .dmem_rdata (dmem_rdata),
        .dmem_raddr (dmem_raddr),
        .dmem_wr    (dmem_wr),
        .retire     (retire)
    );

    hazard_unit u_hazard (
        .rs1_idx (rs1_idx),
        .rs2_idx (rs2_idx),
        .id_ex   (id_ex),
        .ex_mem  (ex_mem),
        .retire  (retire),
        .fwd1    (fwd1),
        .fwd2    (fwd2),
        .stall   (stall)
    );

    // Stores carry rd zero and stay out of the register file
    always_comb begin
        wb       = retire;
        wb.valid = retire.valid && (retire.rd != '0);
    end

    // A taken branch wins, so the interrupt waits a cycle
    assign irq_take = irq && !irq_latch && !branch_taken;
    assign flush    = branch_taken || irq_take || rti_seen;

    // Blocks nested interrupts until RTI
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_latch <= 1'b0;
        end else if (irq_take) begin
            irq_latch <= 1'b1;
        end else if (rti_seen && !branch_taken) begin
            irq_latch <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- rtl/proc_pkg.sv
`default_nettype none

package proc_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_idx_t;

    // Major opcodes of the supported subset
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    // Custom return-from-interrupt
    localparam logic [6:0] OPC_RTI    = 7'b0001000;

    typedef enum logic [3:0] {
        OP_INVALID,
        OP_LUI,
        OP_ADDI,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_LW,
        OP_SW,
        OP_BEQ,
        OP_BNE,
        OP_JAL,
        OP_RTI
    } op_t;

    // Operand source for the execute stage
    typedef enum logic [1:0] {
        REG,
        FROM_MEM,
        FROM_WB
    } fwd_sel_t;

    typedef struct packed {
        xlen_t instr;
        xlen_t pc;
        logic  valid;
    } if_id_t;

    typedef struct packed {
        op_t      op;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        xlen_t    rs1_val;
        xlen_t    rs2_val;
        xlen_t    imm;
        xlen_t    pc;
        logic     reg_write;
        logic     valid;
    } id_ex_t;

    typedef struct packed {
        xlen_t    alu_result;
        xlen_t    store_data;
        xlen_t    pc;
        reg_idx_t rd;
        op_t      op;
        logic     reg_write;
        logic     valid;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        xlen_t    data;
        xlen_t    pc;
    } retire_t;

    typedef struct packed {
        logic  valid;
        xlen_t addr;
        xlen_t data;
    } store_t;

endpackage

`default_nettype wire

//--- sim.f
rtl/proc_pkg.sv
rtl/fetch.sv
rtl/decode.sv
rtl/execute.sv
rtl/memory.sv
rtl/hazard_unit.sv
rtl/proc.sv
verification/tb_proc.sv

//--- verification/tb_proc.sv
`timescale 1ns/1ps
`default_nettype none

module tb_proc import proc_pkg::*;;

    localparam xlen_t BOOT_PC    = 32'h0000_0100;
    localparam xlen_t VEC_PC     = 32'h0000_0800;
    localparam xlen_t HALT_WORD  = 32'h0000_006F;
    localparam xlen_t NO_IRQ     = 32'hFFFF_FFFF;
    localparam xlen_t MARK_ADDR  = 32'h0000_0080;
    localparam int    MAX_CYCLES = 2000;

    logic    clk;
    logic    rst_n;
    logic    irq;
    xlen_t   imem_data;
    xlen_t   dmem_rdata;
    xlen_t   imem_addr;
    xlen_t   dmem_raddr;
    store_t  dmem_wr;
    retire_t retire;

    xlen_t   imem [1024];
    xlen_t   dmem [xlen_t];
    xlen_t   ref_mem [xlen_t];
    int      wr_count;
    retire_t exp_ret [$];
    store_t  exp_st [$];
    xlen_t   pc_ld;
    logic    checking;
    int      cycles;
    int      ret_errors;
    int      st_errors;
    int      other_errors;

    proc #(
        .RESET_PC   (BOOT_PC),
        .IRQ_VECTOR (VEC_PC)
    ) u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .irq        (irq),
        .imem_data  (imem_data),
        .dmem_rdata (dmem_rdata),
        .imem_addr  (imem_addr),
        .dmem_raddr (dmem_raddr),
        .dmem_wr    (dmem_wr),
        .retire     (retire)
    );

    always #2 clk = ~clk;

    // Unwritten data words read back a value tied to their address
    function automatic xlen_t fill_word(xlen_t addr);
        return addr ^ 32'h5A5A_C3C3;
    endfunction

    assign imem_data = imem[imem_addr[11:2]];

    always @(dmem_raddr, wr_count) begin
        dmem_rdata = dmem.exists(dmem_raddr) ? dmem[dmem_raddr] : fill_word(dmem_raddr);
    end

    always @(posedge clk) begin
        if (rst_n && dmem_wr.valid) begin
            dmem[dmem_wr.addr] = dmem_wr.data;
            wr_count++;
        end
    end

    // Instruction encoders
    function automatic xlen_t op_imm(reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, OPC_OP_IMM};
    endfunction

    function automatic xlen_t r_type(logic [6:0] f7, logic [2:0] f3, reg_idx_t rd,
                                     reg_idx_t rs1, reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic xlen_t lui_w(reg_idx_t rd, logic [19:0] imm);
        return {imm, rd, OPC_LUI};
    endfunction

    function automatic xlen_t lw_w(reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, OPC_LOAD};
    endfunction

    function automatic xlen_t sw_w(reg_idx_t rs2, reg_idx_t rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic xlen_t br_w(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2,
                                   logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic xlen_t jal_w(reg_idx_t rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    task automatic emit(xlen_t word);
        imem[pc_ld[11:2]] = word;
        pc_ld += 32'd4;
    endtask

    task automatic load_const(reg_idx_t rd, xlen_t v);
        emit(lui_w(rd, v[31:12] + v[11]));
        emit(op_imm(rd, rd, v[11:0]));
    endtask

    // ISA-level classification of a raw word
    function automatic op_t classify(xlen_t w);
        case (w[6:0])
            OPC_LUI:    return OP_LUI;
            OPC_OP_IMM: return (w[14:12] == 3'b000) ? OP_ADDI : OP_INVALID;
            OPC_LOAD:   return (w[14:12] == 3'b010) ? OP_LW : OP_INVALID;
            OPC_STORE:  return (w[14:12] == 3'b010) ? OP_SW : OP_INVALID;
            OPC_JAL:    return OP_JAL;
            OPC_RTI:    return OP_RTI;
            OPC_BRANCH: begin
                if (w[14:12] == 3'b000) return OP_BEQ;
                if (w[14:12] == 3'b001) return OP_BNE;
                return OP_INVALID;
            end
            OPC_OP: begin
                case ({w[31:25], w[14:12]})
                    10'b0000000_000: return OP_ADD;
                    10'b0100000_000: return OP_SUB;
                    10'b0000000_111: return OP_AND;
                    10'b0000000_110: return OP_OR;
                    10'b0000000_100: return OP_XOR;
                    10'b0000000_010: return OP_SLT;
                    default:         return OP_INVALID;
                endcase
            end
            default: return OP_INVALID;
        endcase
    endfunction

    // Runs the loaded program and queues the expected retires and stores
    function automatic void run_reference(xlen_t irq_pc);
        xlen_t    mr [32];
        xlen_t    pc;
        xlen_t    npc;
        xlen_t    w;
        xlen_t    a;
        xlen_t    b;
        xlen_t    immi;
        xlen_t    res;
        xlen_t    addr;
        xlen_t    epc;
        logic     latch;
        logic     irq_done;
        logic     wr;
        reg_idx_t rd;
        retire_t  r;
        store_t   s;
        for (int i = 0; i < 32; i++) begin
            mr[i] = '0;
        end
        ref_mem.delete();
        pc = BOOT_PC;
        epc = '0;
        latch = 1'b0;
        irq_done = 1'b0;
        for (int step = 0; step < 400; step++) begin
            if (!latch && !irq_done && pc == irq_pc) begin
                epc = pc;
                pc = VEC_PC;
                latch = 1'b1;
                irq_done = 1'b1;
            end
            w = imem[pc[11:2]];
            if (w == HALT_WORD) break;
            rd = w[11:7];
            a = mr[w[19:15]];
            b = mr[w[24:20]];
            immi = {{20{w[31]}}, w[31:20]};
            npc = pc + 32'd4;
            wr = 1'b1;
            res = '0;
            case (classify(w))
                OP_LUI:  res = {w[31:12], 12'b0};
                OP_ADDI: res = a + immi;
                OP_ADD:  res = a + b;
                OP_SUB:  res = a - b;
                OP_AND:  res = a & b;
                OP_OR:   res = a | b;
                OP_XOR:  res = a ^ b;
                OP_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                OP_LW: begin
                    addr = a + immi;
                    res = ref_mem.exists(addr) ? ref_mem[addr] : fill_word(addr);
                end
                OP_SW: begin
                    wr = 1'b0;
                    addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
                    ref_mem[addr] = b;
                    s.valid = 1'b1;
                    s.addr = addr;
                    s.data = b;
                    exp_st.push_back(s);
                    r.valid = 1'b1;
                    r.rd = '0;
                    r.data = b;
                    r.pc = pc;
                    exp_ret.push_back(r);
                end
                OP_BEQ, OP_BNE: begin
                    wr = 1'b0;
                    if ((a == b) == (w[14:12] == 3'b000)) begin
                        npc = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                    end
                end
                OP_JAL: begin
                    res = pc + 32'd4;
                    npc = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                end
                OP_RTI: begin
                    wr = 1'b0;
                    npc = epc;
                    latch = 1'b0;
                end
                default: wr = 1'b0;
            endcase
            if (wr && rd != '0) begin
                mr[rd] = res;
                r.valid = 1'b1;
                r.rd = rd;
                r.data = res;
                r.pc = pc;
                exp_ret.push_back(r);
            end
            pc = npc;
        end
    endfunction

    task automatic build_program(int p);
        xlen_t ra;
        xlen_t rb;
        pc_ld = BOOT_PC;
        case (p)
            0: begin
                ra = $urandom;
                rb = $urandom;
                load_const(1, ra);
                load_const(2, rb);
                emit(r_type(7'h00, 3'b000, 3, 1, 2));
                emit(r_type(7'h20, 3'b000, 4, 1, 2));
                emit(r_type(7'h00, 3'b111, 5, 1, 2));
                emit(r_type(7'h00, 3'b110, 6, 1, 2));
                emit(r_type(7'h00, 3'b100, 7, 1, 2));
                emit(r_type(7'h00, 3'b010, 8, 1, 2));
                emit(r_type(7'h00, 3'b010, 9, 2, 1));
                emit(op_imm(10, 1, 12'($urandom)));
                emit(lui_w(11, 20'($urandom)));
                emit(r_type(7'h00, 3'b010, 12, 1, 1));
            end
            1: begin
                emit(op_imm(1, 0, 12'd5));
                emit(op_imm(2, 1, 12'd3));
                emit(op_imm(3, 1, 12'd7));
                emit(r_type(7'h00, 3'b000, 4, 2, 1));
                emit(r_type(7'h20, 3'b000, 5, 4, 3));
                emit(op_imm(0, 0, 12'd99));
                emit(r_type(7'h00, 3'b000, 6, 0, 1));
                emit(r_type(7'h00, 3'b110, 7, 6, 0));
                emit(op_imm(8, 1, 12'hFFF));
            end
            2: begin
                emit(op_imm(1, 0, 12'h040));
                emit(op_imm(2, 0, 12'd123));
                emit(sw_w(2, 1, 12'd0));
                emit(lw_w(3, 1, 12'd0));
                emit(r_type(7'h00, 3'b000, 4, 3, 3));
                emit(lw_w(5, 1, 12'd8));
                emit(op_imm(6, 5, 12'd1));
                emit(sw_w(6, 1, 12'd4));
                emit(lw_w(7, 1, 12'd4));
                emit(sw_w(7, 1, 12'd12));
            end
            3: begin
                emit(op_imm(1, 0, 12'd1));
                emit(op_imm(2, 0, 12'd1));
                emit(op_imm(3, 0, 12'd2));
                emit(br_w(3'b000, 1, 2, 13'd8));
                emit(op_imm(4, 0, 12'd111));
                emit(br_w(3'b001, 1, 3, 13'd8));
                emit(op_imm(4, 0, 12'd222));
                emit(br_w(3'b000, 1, 3, 13'd8));
                emit(op_imm(5, 0, 12'd5));
                emit(br_w(3'b001, 1, 2, 13'd8));
                emit(op_imm(6, 0, 12'd6));
                emit(jal_w(7, 21'd8));
                emit(op_imm(8, 0, 12'd8));
                emit(op_imm(9, 7, 12'd0));
            end
            default: begin
                // Idle loop at BOOT_PC + 0x10 polls x10, set by the handler
                emit(op_imm(10, 0, 12'd0));
                emit(op_imm(8, 0, MARK_ADDR[11:0]));
                emit(op_imm(11, 0, 12'h5A5));
                emit(op_imm(12, 0, 12'h123));
                emit(br_w(3'b000, 10, 0, 13'd0));
                emit(sw_w(12, 8, 12'd4));
                emit(HALT_WORD);
                pc_ld = VEC_PC;
                emit(op_imm(10, 0, 12'd1));
                emit(sw_w(11, 8, 12'd0));
                repeat (4) emit(op_imm(0, 0, 12'd0));
                emit({25'b0, OPC_RTI});
            end
        endcase
        emit(HALT_WORD);
    endtask

    task automatic check_retire(retire_t got, retire_t exp);
        if (got !== exp) begin
            ret_errors++;
            $display("Fail %0t ns: retire rd=%0d data=%h pc=%h, expected rd=%0d data=%h pc=%h",
                     $time, got.rd, got.data, got.pc, exp.rd, exp.data, exp.pc);
        end
    endtask

    task automatic check_store(store_t got, store_t exp);
        if (got !== exp) begin
            st_errors++;
            $display("Fail %0t ns: store addr=%h data=%h, expected addr=%h data=%h",
                     $time, got.addr, got.data, exp.addr, exp.data);
        end
    endtask

    always @(negedge clk) begin
        if (rst_n && checking) begin
            if (retire.valid) begin
                if (exp_ret.size() == 0) begin
                    other_errors++;
                    $display("Unexpected retire at %0t ns from pc %h", $time, retire.pc);
                end else begin
                    check_retire(retire, exp_ret.pop_front());
                end
            end
            if (dmem_wr.valid) begin
                if (exp_st.size() == 0) begin
                    other_errors++;
                    $display("Unexpected store at %0t ns to %h", $time, dmem_wr.addr);
                end else begin
                    check_store(dmem_wr, exp_st.pop_front());
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles with %0d retires and %0d stores pending",
                     cycles, exp_ret.size(), exp_st.size());
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic expect_idle(int n);
        repeat (n) begin
            @(negedge clk);
            if (retire.valid !== 1'b0 || dmem_wr.valid !== 1'b0) begin
                other_errors++;
                $display("Retire or store valid at %0t ns before any instruction could finish",
                         $time);
            end
        end
    endtask

    // Hold irq until the handler's marker store shows up
    task automatic drive_irq();
        repeat (25) @(posedge clk);
        #1 irq = 1'b1;
        do @(negedge clk); while (!(dmem_wr.valid && dmem_wr.addr == MARK_ADDR));
        @(posedge clk);
        #1 irq = 1'b0;
    endtask

    task automatic run_program(int p);
        @(posedge clk);
        #1 rst_n = 1'b0;
        checking = 1'b0;
        for (int i = 0; i < 1024; i++) begin
            imem[i] = '0;
        end
        dmem.delete();
        exp_ret.delete();
        exp_st.delete();
        build_program(p);
        run_reference((p == 4) ? BOOT_PC + 32'h10 : NO_IRQ);
        expect_idle(5);
        @(posedge clk);
        #1 rst_n = 1'b1;
        checking = 1'b1;
        if (p == 4) begin
            fork
                drive_irq();
            join_none
        end
        expect_idle(3);
        while (exp_ret.size() != 0 || exp_st.size() != 0) begin
            @(posedge clk);
        end
        repeat (8) @(posedge clk);
        wait fork;
    endtask

    initial begin
        void'($urandom(14836));
        clk = 1'b0;
        rst_n = 1'b0;
        irq = 1'b0;
        checking = 1'b0;
        wr_count = 0;
        cycles = 0;
        ret_errors = 0;
        st_errors = 0;
        other_errors = 0;
        for (int p = 0; p < 5; p++) begin
            run_program(p);
        end
        $display("Errors: retire %0d, store %0d, other %0d",
                 ret_errors, st_errors, other_errors);
        if (ret_errors + st_errors + other_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
